// File: sim.f
+incdir+.
stepper_pkg.sv
step_rate_divider.sv
step_command.sv
step_pulse_gen.sv
position_tracker.sv
stepper_axis.sv
tb_stepper_axis.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_stepper_axis
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@result="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: stepper_stimulus.txt
// Columns: step count (8-bit two's complement), expected pulses, expected dir,
// expected position after the move (16-bit two's complement). All values are hex.
05 05 0 0005
fd 03 1 0002
7f 7f 0 0081
80 80 1 0001
00 00 1 0001
01 01 0 0002
80 80 1 ff82
80 80 1 ff02
0a 0a 0 ff0c
f6 0a 1 ff02
00 00 1 ff02
40 40 0 ff42
81 7f 1 fec3
02 02 0 fec5
ff 01 1 fec4
7f 7f 0 ff43
03 03 0 ff46

// File: tb_stepper_axis.sv
`include "stepper_config.svh"

module tb_stepper_axis;

	localparam int MAX_MOVES = 64; // Capacity of the stimulus table.
	localparam int WORDS_PER_MOVE = 4; // Count, pulses, dir and position.
	localparam int MAX_GAP = 7; // Longest idle gap in cycles and the mask for random gaps.
	localparam int DRIVE_DELAY = 1; // Inputs change this long after the rising edge.
	localparam int IDLE_WAIT = 4 * `STEP_DIV; // Cycles watched after a zero count.
	localparam int MOVE_BUDGET = 2 * 128 * `STEP_DIV + MAX_GAP + IDLE_WAIT + 64;
	localparam stepper_pkg::step_count_t INTRUDER = stepper_pkg::step_count_t'(-7);

	logic                     clk;       // Testbench clock.
	logic                     reset;     // Synchronous reset of the DUT.
	logic                     trigger;   // Host strobe.
	stepper_pkg::step_count_t num_steps; // Signed count for the next move.
	logic                     out;       // Step pulse line.
	logic                     dir;       // Direction level.
	logic                     done;      // High while the axis is idle.
	stepper_pkg::step_pos_t   position;  // Commanded position.

	logic [15:0] stim_words [0:MAX_MOVES*WORDS_PER_MOVE-1]; // Raw stimulus table.
	int          num_moves;   // Moves found in the stimulus file.
	int          pulse_total; // Rising edges of out since reset.
	logic        out_prev;    // Out at the previous falling clock edge.
	logic        exp_dir;     // Direction expected for the current move.
	int          seed;        // Seed for the idle gaps.

	stepper_axis DUT (
		.clk      (clk),
		.reset    (reset),
		.trigger  (trigger),
		.num_steps(num_steps),
		.out      (out),
		.dir      (dir),
		.done     (done),
		.position (position)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk; // Period of 4 time units.

	task automatic report_failure(input string msg);
		$display("CHECK FAILED at time %0t: %s", $time, msg);
		$display("Test failures found");
		$fatal(1, "Stopping at the first error.");
	endtask

	// Drives a one-cycle trigger just after the rising edge.
	task automatic drive_trigger(input stepper_pkg::step_count_t count);
		@(posedge clk);
		#DRIVE_DELAY;
		trigger   = 1'b1;
		num_steps = count;
		@(posedge clk);
		#DRIVE_DELAY;
		trigger   = 1'b0; // The DUT saw the strobe on exactly one edge.
	endtask

	// Samples one falling edge and expects a quiet axis at the given position.
	task automatic check_idle(input stepper_pkg::step_pos_t pos);
		@(negedge clk);
		assert (done && !out) else report_failure("axis is not idle between moves");
		assert (position == pos) else
			report_failure($sformatf("position %0d while idle, expected %0d",
				position, pos));
	endtask

	// Counts step pulses on the falling edge, where out and dir are settled.
	always @(negedge clk) begin
		if (reset) begin
			pulse_total = 0; // Nothing counted before the first move.
			out_prev    = 1'b0;
		end else begin
			if (out && !out_prev) begin
				pulse_total = pulse_total + 1; // One more rising edge of out.
				assert (dir == exp_dir) else
					report_failure($sformatf("dir %0b at a step pulse, expected %0b",
						dir, exp_dir));
			end
			assert (!(done && out)) else
				report_failure("out is high while done is high");
			out_prev = out;
		end
	end

	initial begin : main
		stepper_pkg::step_count_t count;       // Count of the current entry.
		stepper_pkg::step_pos_t   exp_pos;     // Position expected after it.
		stepper_pkg::step_pos_t   prev_pos;    // Position before it.
		int                       exp_pulses;  // Pulses expected for it.
		int                       start_total; // Pulse total before the trigger.
		int                       gap;         // Idle cycles before the trigger.
		int                       waited;      // Cycles spent waiting for done to fall.
		int                       k;
		seed      = 50467;
		reset     = 1'b1;
		trigger   = 1'b0;
		num_steps = '0;
		exp_dir   = 1'b0;
		// Unloaded words keep a top nibble of F, above any pulse count.
		for (k = 0; k < MAX_MOVES * WORDS_PER_MOVE; k++) begin
			stim_words[k] = {4'hF, 12'(k)};
		end
		$readmemh("stepper_stimulus.txt", stim_words);
		num_moves = 0;
		while (num_moves < MAX_MOVES &&
			stim_words[num_moves*WORDS_PER_MOVE+1][15:12] != 4'hF) begin
			num_moves++;
		end
		if (num_moves == 0) begin
			$display("No moves could be read from stepper_stimulus.txt.");
			$display("Test failures found");
			$fatal(1, "Empty stimulus file.");
		end
		repeat (8) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		@(negedge clk);
		assert (done && !out && !dir && position == '0) else
			report_failure("outputs are not at their reset values");
		prev_pos = '0;
		for (k = 0; k < num_moves; k++) begin
			count      = stepper_pkg::step_count_t'(stim_words[WORDS_PER_MOVE*k][7:0]);
			exp_pulses = int'(stim_words[WORDS_PER_MOVE*k+1]);
			exp_pos    = stepper_pkg::step_pos_t'(stim_words[WORDS_PER_MOVE*k+3]);
			gap        = $random(seed) & MAX_GAP; // Random idle time before the move.
			repeat (gap) check_idle(prev_pos);
			exp_dir     = stim_words[WORDS_PER_MOVE*k+2][0];
			start_total = pulse_total;
			drive_trigger(count);
			if (exp_pulses == 0) begin
				repeat (IDLE_WAIT) check_idle(prev_pos); // Dropped count, no pulse and no move.
			end else begin
				waited = 0;
				@(negedge clk);
				while (done && waited < 4) begin
					@(negedge clk);
					waited++;
				end
				assert (!done) else
					report_failure("done stayed high after an accepted trigger");
				while (pulse_total == start_total && !done) @(negedge clk);
				drive_trigger(INTRUDER); // Arrives mid-move and must be ignored.
				while (!done) @(negedge clk);
				assert (pulse_total - start_total == exp_pulses) else
					report_failure($sformatf("move %0d gave %0d pulses, expected %0d",
						k, pulse_total - start_total, exp_pulses));
			end
			assert (position == exp_pos) else
				report_failure($sformatf("move %0d ended at position %0d, expected %0d",
					k, position, exp_pos));
			prev_pos = exp_pos;
		end
		repeat (IDLE_WAIT) check_idle(prev_pos); // Nothing moves after the last done.
		$display("All tests passed!");
		$finish;
	end

	// Budget per move covers the longest train, the idle gap and the trigger latency.
	initial begin : watchdog
		int limit;
		@(negedge reset);
		limit = num_moves * MOVE_BUDGET + 2 * IDLE_WAIT + 100;
		repeat (limit) @(posedge clk);
		$display("Timeout at time %0t: the moves did not all finish in time.", $time);
		$display("Test failures found");
		$fatal(1, "Watchdog expired.");
	end

endmodule : tb_stepper_axis

// File: stepper_axis.sv
module stepper_axis (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     trigger,
	input  stepper_pkg::step_count_t num_steps,
	output logic                     out,
	output logic                     dir,
	output logic                     done,
	output stepper_pkg::step_pos_t   position
);

	logic                   tick;       // Shared step rate tick.
	stepper_pkg::step_cmd_t cmd;        // Accepted move for the generator.
	logic                   busy;       // A move is in progress.
	logic                   step_event; // One step was issued.

	// Prescaler for the whole axis.
	step_rate_divider u_rate (
		.clk  (clk),
		.reset(reset),
		.tick (tick)
	);

	// Filters triggers and converts the count.
	step_command u_command (
		.clk      (clk),
		.reset    (reset),
		.trigger  (trigger),
		.num_steps(num_steps),
		.busy     (busy),
		.cmd      (cmd)
	);

	// Builds the pulse train.
	step_pulse_gen u_pulse (
		.clk       (clk),
		.reset     (reset),
		.tick      (tick),
		.cmd       (cmd),
		.out       (out),
		.dir       (dir),
		.done      (done),
		.busy      (busy),
		.step_event(step_event)
	);

	// Direction comes from the generator, stable for the whole move.
	position_tracker u_position (
		.clk       (clk),
		.reset     (reset),
		.step_event(step_event),
		.dir       (dir),
		.position  (position)
	);

endmodule : stepper_axis

// File: position_tracker.sv
module position_tracker (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   step_event,
	input  logic                   dir,
	output stepper_pkg::step_pos_t position
);

	stepper_pkg::step_pos_t delta; // Signed change for one step.

	// Plus one forward, minus one in reverse.
	always_comb begin
		if (dir) begin
			delta = '1; // All ones is -1 in two's complement.
		end else begin
			delta = stepper_pkg::step_pos_t'(1); // One step forward.
		end
	end

	// The sum wraps at the position width, as a plain counter would.
	always_ff @(posedge clk) begin
		if (reset) begin
			position <= '0; // Home after reset.
		end else if (step_event) begin
			position <= position + delta; // Applied one cycle after the event.
		end
	end

endmodule : position_tracker

// File: step_pulse_gen.sv
module step_pulse_gen (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   tick,
	input  stepper_pkg::step_cmd_t cmd,
	output logic                   out,
	output logic                   dir,
	output logic                   done,
	output logic                   busy,
	output logic                   step_event
);

	stepper_pkg::pulse_state_t state;     // Current phase of the pulse train.
	stepper_pkg::step_mag_t    remaining; // Steps still to be emitted.

	// A move runs as alternating ticks. A tick in pulse_high raises out when
	// steps remain, a tick in pulse_low lowers it and counts the step off.
	// The tick in pulse_high that finds no steps left ends the last low
	// phase and returns to idle, so the final low level lasts a full tick.
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= stepper_pkg::pulse_idle; // Idle with done high.
			remaining  <= '0; // Nothing to emit.
			out        <= 1'b0; // Step line low.
			dir        <= 1'b0; // Default direction.
			step_event <= 1'b0; // No step reported.
		end else begin
			step_event <= 1'b0; // Pulses only on a rising step.
			case (state)
				stepper_pkg::pulse_idle: begin
					out <= 1'b0; // Line stays low between moves.
					if (cmd.valid) begin
						dir       <= cmd.dir; // Held for the whole move.
						remaining <= cmd.mag; // The command stage passes no zero count.
						state     <= stepper_pkg::pulse_high; // done falls here.
					end
				end
				stepper_pkg::pulse_high: begin
					if (tick) begin
						if (remaining == '0) begin
							state <= stepper_pkg::pulse_idle; // Last low phase is over.
						end else begin
							out        <= 1'b1; // Start of one step pulse.
							step_event <= 1'b1; // Tell the position tracker.
							state      <= stepper_pkg::pulse_low;
						end
					end
				end
				stepper_pkg::pulse_low: begin
					if (tick) begin
						out       <= 1'b0; // End of the high half.
						remaining <= remaining - 1'b1; // One step finished.
						state     <= stepper_pkg::pulse_high;
					end
				end
				default: begin
					state <= stepper_pkg::pulse_idle; // Recover from an unused code.
					out   <= 1'b0;
				end
			endcase
		end
	end

	// Done is a level, high whenever no move is in progress.
	assign done = (state == stepper_pkg::pulse_idle);

	// Busy goes back to the command stage and blocks new triggers.
	assign busy = ~done;

endmodule : step_pulse_gen

// File: step_command.sv
module step_command (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     trigger,
	input  stepper_pkg::step_count_t num_steps,
	input  logic                     busy,
	output stepper_pkg::step_cmd_t   cmd
);

	localparam int SIGN_BIT = $bits(stepper_pkg::step_count_t) - 1; // Count sign bit.

	logic                   neg;     // The requested count is negative.
	stepper_pkg::step_mag_t mag_in;  // Magnitude of the requested count.
	logic                   accept;  // The trigger starts a move this cycle.

	// Split the signed count into a direction and an unsigned magnitude.
	// Negation in the unsigned type turns -128 into 128 without overflow.
	always_comb begin
		neg = num_steps[SIGN_BIT]; // Sign bit gives the direction.
		if (neg) begin
			mag_in = stepper_pkg::step_mag_t'(0) - stepper_pkg::step_mag_t'(num_steps);
		end else begin
			mag_in = stepper_pkg::step_mag_t'(num_steps); // Positive count as is.
		end
	end

	// The generator only goes busy on the edge that sees cmd.valid, so a
	// pending command blocks a second trigger for that one cycle too.
	assign accept = trigger && !busy && !cmd.valid && (mag_in != '0);

	// Start strobe for the pulse generator.
	always_ff @(posedge clk) begin
		if (reset) begin
			cmd.valid <= 1'b0; // No command after reset.
		end else begin
			cmd.valid <= accept; // High for the single cycle after an accepted trigger.
		end
	end

	// Direction and magnitude of the last accepted move.
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd.dir <= neg; // 1 for a negative count.
			cmd.mag <= mag_in; // Steps to emit.
		end
	end

endmodule : step_command

// File: step_rate_divider.sv
`include "stepper_config.svh"

module step_rate_divider (
	input  logic clk,
	input  logic reset,
	output logic tick
);

	localparam int DIV = `STEP_DIV; // Cycles between two ticks.
	localparam int CNT_BITS = (DIV > 1) ? $clog2(DIV) : 1; // At least one bit.
	localparam logic [CNT_BITS-1:0] LAST = CNT_BITS'(DIV - 1); // Wrap point.

	logic [CNT_BITS-1:0] count; // Cycles since the last tick.

	// The counter runs freely from reset, so the tick phase is fixed by reset
	// alone and does not move with the host's triggers.
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0; // Restart the prescaler phase.
			tick  <= 1'b0; // No tick during reset.
		end else if (count == LAST) begin
			count <= '0; // Wrap to the start of the period.
			tick  <= 1'b1; // One-cycle tick at the wrap.
		end else begin
			count <= count + 1'b1; // Keep counting toward the wrap.
			tick  <= 1'b0; // Tick lasts only one cycle.
		end
	end

endmodule : step_rate_divider

// File: stepper_pkg.sv
`include "stepper_config.svh"

package stepper_pkg;

	// Signed step count exactly as the host drives it on num_steps.
	typedef logic signed [`STEP_COUNT_BITS-1:0] step_count_t;

	// Unsigned magnitude; the same width holds 128 for a count of -128.
	typedef logic [`STEP_COUNT_BITS-1:0] step_mag_t;

	// Signed commanded position that wraps on overflow.
	typedef logic signed [`STEP_POS_BITS-1:0] step_pos_t;

	// One accepted move, passed from the command stage to the pulse generator.
	typedef struct packed {
		logic      valid; // One-cycle strobe for a new move.
		logic      dir;   // Set for a negative count.
		step_mag_t mag;   // Number of steps, never zero when valid.
	} step_cmd_t;

	// Pulse generator states.
	typedef enum logic [1:0] {
		pulse_idle = 2'd0, // No move in progress, done is high.
		pulse_high = 2'd1, // Waiting for the tick that raises out.
		pulse_low  = 2'd2  // Waiting for the tick that lowers out.
	} pulse_state_t;

endpackage : stepper_pkg

// File: stepper_config.svh
`ifndef STEPPER_CONFIG_SVH
`define STEPPER_CONFIG_SVH

// Width of the signed step count that the host writes with each trigger.
`define STEP_COUNT_BITS 8

// Width of the signed running position, wide enough for many full moves.
`define STEP_POS_BITS 16

// Clock cycles per step tick. Each step takes two ticks, one high and one low.
`define STEP_DIV 4

`endif
